//--- include/mem_map.svh
`ifndef MEM_MAP_SVH
`define MEM_MAP_SVH

// base of the SRAM window
`define MEM_BASE 32'h8000_0000

// console byte sink
`define SERIAL_ADDR 32'ha000_03f8

// true when addr falls in a window of the given number of 64-bit words
`define MEM_IN_RANGE(addr, words) \
  (((addr) >= `MEM_BASE) && ((addr) < (`MEM_BASE + (words) * 8)))

`endif

//--- hw/axi_bus_pkg.sv
`default_nettype none

package axi_bus_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 64;
  localparam int unsigned ID_W   = 4;
  localparam int unsigned STRB_W = DATA_W / 8;

  // standard AXI response encodings, EXOKAY never produced
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  // single beat only, so no len/size/burst fields
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  // rlast is implied high on every beat
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } axi_r_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_e       resp;
  } axi_b_t;

endpackage

`default_nettype wire

//--- hw/mem_dev_pkg.sv
`default_nettype none

package mem_dev_pkg;

  import axi_bus_pkg::*;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    CAP_IDLE     = 2'b00,
    CAP_WAIT_RSP = 2'b01
  } cap_state_e;

  // one request to the memory device
  typedef struct packed {
    mem_op_e           op;
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } mem_req_t;

  typedef struct packed {
    mem_op_e           op;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] rdata;
    axi_resp_e         resp;
  } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/axi_req_capture.sv
`timescale 1ns/10ps
`default_nettype none

module axi_req_capture #(
  parameter bit          STALL_EN  = 1'b0,
  parameter logic [19:0] LFSR_SEED = 20'h00065
) (
  input  wire                       clk,
  input  wire                       rst_i,
  input  wire                       ar_valid_i,
  output logic                      ar_ready_o,
  input  wire axi_bus_pkg::axi_ar_t ar_i,
  input  wire                       aw_valid_i,
  output logic                      aw_ready_o,
  input  wire axi_bus_pkg::axi_aw_t aw_i,
  input  wire                       w_valid_i,
  output logic                      w_ready_o,
  input  wire axi_bus_pkg::axi_w_t  w_i,
  input  wire                       rsp_done_i,
  output logic                      req_valid_o,
  output mem_dev_pkg::mem_req_t     req_o
);

  import mem_dev_pkg::*;

  cap_state_e  state_q;
  logic [19:0] lfsr_q;
  logic        stall_ok;
  logic        idle;
  logic        accept_rd;
  logic        accept_wr;
  logic        req_valid_q;
  mem_req_t    req_q;

  // pseudo-random throttle, only the top bit matters
  always_ff @(posedge clk) begin
    if (rst_i) begin
      lfsr_q <= LFSR_SEED;
    end else begin
      lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ^ lfsr_q[18]};
    end
  end

  assign stall_ok = STALL_EN ? lfsr_q[19] : 1'b1;
  assign idle     = (state_q == CAP_IDLE);

  assign ar_ready_o = idle && stall_ok && ar_valid_i;

  // AW and W go together, and only when no read is waiting
  assign aw_ready_o = idle && stall_ok && aw_valid_i && w_valid_i && !ar_valid_i;
  assign w_ready_o  = aw_ready_o;

  assign accept_rd = ar_valid_i && ar_ready_o;
  assign accept_wr = aw_valid_i && aw_ready_o && w_valid_i && w_ready_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q     <= CAP_IDLE;
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= accept_rd || accept_wr;
      case (state_q)
        CAP_IDLE: begin
          if (accept_rd || accept_wr) begin
            state_q <= CAP_WAIT_RSP;
          end
        end
        CAP_WAIT_RSP: begin
          // released once the master takes the response
          if (rsp_done_i) begin
            state_q <= CAP_IDLE;
          end
        end
        default: state_q <= CAP_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept_rd) begin
      req_q.op    <= MEM_READ;
      req_q.id    <= ar_i.id;
      req_q.addr  <= ar_i.addr;
      req_q.wdata <= '0;
      req_q.strb  <= '0;
    end else if (accept_wr) begin
      req_q.op    <= MEM_WRITE;
      req_q.id    <= aw_i.id;
      req_q.addr  <= aw_i.addr;
      req_q.wdata <= w_i.data;
      req_q.strb  <= w_i.strb;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

endmodule

`default_nettype wire

//--- hw/mem_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_map.svh"

module mem_core #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  wire                        clk,
  input  wire                        rst_i,
  input  wire                        req_valid_i,
  input  wire mem_dev_pkg::mem_req_t req_i,
  output logic                       rsp_valid_o,
  output mem_dev_pkg::mem_rsp_t      rsp_o,
  output logic                       uart_valid_o,
  output logic [7:0]                 uart_data_o
);

  import axi_bus_pkg::*;
  import mem_dev_pkg::*;

  localparam int unsigned IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [DATA_W-1:0] mem_q [MEM_WORDS];

  logic [ADDR_W-1:0] req_offset;
  logic [IDX_W-1:0]  word_idx;
  logic              hit_mem;
  logic              hit_serial;
  logic              mem_we;
  mem_rsp_t          rsp_d;
  mem_rsp_t          rsp_q;
  logic              rsp_valid_q;
  logic              uart_valid_q;
  logic [7:0]        uart_data_q;

  // address decode
  assign hit_mem    = `MEM_IN_RANGE(req_i.addr, MEM_WORDS);
  assign hit_serial = (req_i.addr == `SERIAL_ADDR);
  assign req_offset = req_i.addr - `MEM_BASE;
  assign word_idx   = IDX_W'(req_offset >> 3);
  assign mem_we     = req_valid_i && hit_mem && (req_i.op == MEM_WRITE);

  always_comb begin
    rsp_d.op    = req_i.op;
    rsp_d.id    = req_i.id;
    rsp_d.rdata = '0;
    rsp_d.resp  = OKAY;
    if (hit_mem) begin
      if (req_i.op == MEM_READ) begin
        rsp_d.rdata = mem_q[word_idx];
      end
    end else if (!hit_serial) begin
      rsp_d.resp = DECERR;
    end
  end

  // byte-strobed write
  always_ff @(posedge clk) begin
    if (mem_we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.strb[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_q  <= 1'b0;
      uart_valid_q <= 1'b0;
    end else begin
      rsp_valid_q  <= req_valid_i;
      uart_valid_q <= req_valid_i && hit_serial && (req_i.op == MEM_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i) begin
      rsp_q       <= rsp_d;
      uart_data_q <= req_i.wdata[7:0];
    end
  end

  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_o        = rsp_q;
  assign uart_valid_o = uart_valid_q;
  assign uart_data_o  = uart_data_q;

endmodule

`default_nettype wire

//--- hw/axi_resp_gen.sv
`timescale 1ns/10ps
`default_nettype none

module axi_resp_gen (
  input  wire                        clk,
  input  wire                        rst_i,
  input  wire                        rsp_valid_i,
  input  wire mem_dev_pkg::mem_rsp_t rsp_i,
  output logic                       r_valid_o,
  input  wire                        r_ready_i,
  output axi_bus_pkg::axi_r_t        r_o,
  output logic                       b_valid_o,
  input  wire                        b_ready_i,
  output axi_bus_pkg::axi_b_t        b_o,
  output logic                       rsp_done_o
);

  import mem_dev_pkg::*;

  logic     pend_q;
  mem_rsp_t held_q;
  mem_rsp_t cur_rsp;
  logic     active;
  logic     handshake;

  // first cycle passes straight through, later cycles come from the hold register
  assign cur_rsp = pend_q ? held_q : rsp_i;
  assign active  = rsp_valid_i || pend_q;

  assign r_valid_o = active && (cur_rsp.op == MEM_READ);
  assign b_valid_o = active && (cur_rsp.op == MEM_WRITE);

  assign r_o.id   = cur_rsp.id;
  assign r_o.data = cur_rsp.rdata;
  assign r_o.resp = cur_rsp.resp;
  assign b_o.id   = cur_rsp.id;
  assign b_o.resp = cur_rsp.resp;

  assign handshake  = (r_valid_o && r_ready_i) || (b_valid_o && b_ready_i);
  assign rsp_done_o = handshake;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      pend_q <= 1'b0;
    end else if (handshake) begin
      pend_q <= 1'b0;
    end else if (rsp_valid_i) begin
      pend_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_valid_i) begin
      held_q <= rsp_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/axi_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_top #(
  parameter int unsigned MEM_WORDS = 256,
  parameter bit          STALL_EN  = 1'b0,
  parameter logic [19:0] LFSR_SEED = 20'h00065
) (
  input  wire                       clk,
  input  wire                       rst_i,
  input  wire                       ar_valid_i,
  output logic                      ar_ready_o,
  input  wire axi_bus_pkg::axi_ar_t ar_i,
  input  wire                       aw_valid_i,
  output logic                      aw_ready_o,
  input  wire axi_bus_pkg::axi_aw_t aw_i,
  input  wire                       w_valid_i,
  output logic                      w_ready_o,
  input  wire axi_bus_pkg::axi_w_t  w_i,
  output logic                      r_valid_o,
  input  wire                       r_ready_i,
  output axi_bus_pkg::axi_r_t       r_o,
  output logic                      b_valid_o,
  input  wire                       b_ready_i,
  output axi_bus_pkg::axi_b_t       b_o,
  output logic                      uart_valid_o,
  output logic [7:0]                uart_data_o
);

  import mem_dev_pkg::*;

  logic     req_valid;
  mem_req_t req;
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     rsp_done;

  axi_req_capture #(
    .STALL_EN (STALL_EN),
    .LFSR_SEED(LFSR_SEED)
  ) axi_req_capture_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .ar_valid_i (ar_valid_i),
    .ar_ready_o (ar_ready_o),
    .ar_i       (ar_i),
    .aw_valid_i (aw_valid_i),
    .aw_ready_o (aw_ready_o),
    .aw_i       (aw_i),
    .w_valid_i  (w_valid_i),
    .w_ready_o  (w_ready_o),
    .w_i        (w_i),
    .rsp_done_i (rsp_done),
    .req_valid_o(req_valid),
    .req_o      (req)
  );

  mem_core #(
    .MEM_WORDS(MEM_WORDS)
  ) mem_core_i (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid),
    .req_i       (req),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .uart_valid_o(uart_valid_o),
    .uart_data_o (uart_data_o)
  );

  axi_resp_gen axi_resp_gen_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .rsp_valid_i(rsp_valid),
    .rsp_i      (rsp),
    .r_valid_o  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .r_o        (r_o),
    .b_valid_o  (b_valid_o),
    .b_ready_i  (b_ready_i),
    .b_o        (b_o),
    .rsp_done_o (rsp_done)
  );

endmodule

`default_nettype wire

//--- verif/axi_mem_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_assertions (
  input wire                       clk,
  input wire                       rst_i,
  input wire                       ar_valid_i,
  input wire                       ar_ready_o,
  input wire axi_bus_pkg::axi_ar_t ar_i,
  input wire                       aw_valid_i,
  input wire                       aw_ready_o,
  input wire axi_bus_pkg::axi_aw_t aw_i,
  input wire                       w_valid_i,
  input wire                       w_ready_o,
  input wire axi_bus_pkg::axi_w_t  w_i,
  input wire                       r_valid_o,
  input wire                       r_ready_i,
  input wire axi_bus_pkg::axi_r_t  r_o,
  input wire                       b_valid_o,
  input wire                       b_ready_i,
  input wire axi_bus_pkg::axi_b_t  b_o
);

  int unsigned fail_count = 0;

  // requests hold until accepted
  assert property (@(posedge clk) disable iff (rst_i)
    ar_valid_i && !ar_ready_o |=> ar_valid_i && $stable(ar_i))
  else begin
    fail_count++;
    $error("AR valid or payload changed before its handshake");
  end

  assert property (@(posedge clk) disable iff (rst_i)
    aw_valid_i && w_valid_i && !aw_ready_o |=> aw_valid_i && w_valid_i &&
                                               $stable(aw_i) && $stable(w_i))
  else begin
    fail_count++;
    $error("AW/W valid or payload changed before its handshake");
  end

  // responses hold under back-pressure
  assert property (@(posedge clk) disable iff (rst_i)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_o))
  else begin
    fail_count++;
    $error("R valid or payload changed while held");
  end

  assert property (@(posedge clk) disable iff (rst_i)
    b_valid_o && !b_ready_i |=> b_valid_o && $stable(b_o))
  else begin
    fail_count++;
    $error("B valid or payload changed while held");
  end

  // two cycles from accept to response, in both directions
  assert property (@(posedge clk) disable iff (rst_i)
    (ar_valid_i && ar_ready_o) |-> ##2 r_valid_o)
  else begin
    fail_count++;
    $error("R response not two cycles after the AR accept");
  end

  assert property (@(posedge clk) disable iff (rst_i)
    (aw_valid_i && aw_ready_o) |-> ##2 b_valid_o)
  else begin
    fail_count++;
    $error("B response not two cycles after the AW/W accept");
  end

  assert property (@(posedge clk) disable iff (rst_i)
    $rose(r_valid_o || b_valid_o) |->
      $past((ar_valid_i && ar_ready_o) || (aw_valid_i && aw_ready_o), 2))
  else begin
    fail_count++;
    $error("response raised without an accept two cycles before");
  end

  assert property (@(posedge clk) disable iff (rst_i)
    (r_valid_o || b_valid_o) |-> !ar_ready_o && !aw_ready_o && !w_ready_o)
  else begin
    fail_count++;
    $error("ready output high while a response is pending");
  end

endmodule

`default_nettype wire

//--- verif/tb_axi_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "mem_map.svh"

module tb_axi_mem;

  import axi_bus_pkg::*;

  localparam int unsigned TB_WORDS     = 32;
  localparam int unsigned RESET_CYCLES = 5;
  localparam int unsigned RAND_TXN     = 200;
  // prefill, directed tests and the random mix
  localparam int unsigned NUM_TXN      = TB_WORDS + 14 + RAND_TXN;
  localparam int unsigned MAX_CYCLES   = RESET_CYCLES + 40 * NUM_TXN;

  typedef struct packed {
    logic              is_read;
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    axi_resp_e         resp;
  } exp_t;

  logic    clk;
  logic    rst_i;
  logic    ar_valid_i;
  logic    ar_ready_o;
  axi_ar_t ar_i;
  logic    aw_valid_i;
  logic    aw_ready_o;
  axi_aw_t aw_i;
  logic    w_valid_i;
  logic    w_ready_o;
  axi_w_t  w_i;
  logic    r_valid_o;
  logic    r_ready_i;
  axi_r_t  r_o;
  logic    b_valid_o;
  logic    b_ready_i;
  axi_b_t  b_o;
  logic    uart_valid_o;
  logic [7:0] uart_data_o;

  integer      seed = 32'he38e;
  integer      ready_seed = 32'he38e;
  int unsigned errors;
  int unsigned cycles;
  int unsigned checked;
  int unsigned uart_pulses;
  int unsigned serial_writes;

  // reference model state
  logic [DATA_W-1:0] ref_mem [int unsigned];
  exp_t              exp_q [$];
  logic [7:0]        uart_q [$];

  exp_t   exp_cur;
  logic   r_held;
  axi_r_t r_last;
  logic   b_held;
  axi_b_t b_last;

  axi_mem_top #(
    .MEM_WORDS(TB_WORDS),
    .STALL_EN (1'b1),
    .LFSR_SEED(20'h3c5a1)
  ) axi_mem_top_i (.*);

  bind axi_mem_top axi_mem_assertions assertions_i (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // expected response per the memory map, applies writes to the model
  function automatic exp_t ref_access(input logic is_read, input logic [ID_W-1:0] id,
                                      input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] wdata,
                                      input logic [STRB_W-1:0] strb);
    exp_t              e;
    int unsigned       idx;
    logic [DATA_W-1:0] word;
    e.is_read = is_read;
    e.id      = id;
    e.data    = '0;
    e.resp    = OKAY;
    if (`MEM_IN_RANGE(addr, TB_WORDS)) begin
      idx  = (addr - `MEM_BASE) >> 3;
      word = ref_mem.exists(idx) ? ref_mem[idx] : 'x;
      if (is_read) begin
        e.data = word;
      end else begin
        for (int b = 0; b < STRB_W; b++) begin
          if (strb[b]) begin
            word[b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
        ref_mem[idx] = word;
      end
    end else if (addr == `SERIAL_ADDR) begin
      if (!is_read) begin
        uart_q.push_back(wdata[7:0]);
        serial_writes++;
      end
    end else begin
      e.resp = DECERR;
    end
    return e;
  endfunction

  // AW and W must be taken in the same cycle
  task automatic wait_write_accept();
    @(negedge clk);
    while (!aw_ready_o && !w_ready_o) @(negedge clk);
    assert (aw_ready_o && w_ready_o) else begin
      errors++;
      $display("FAILED @ %0t: AW ready %b and W ready %b, expected both high", $time,
               aw_ready_o, w_ready_o);
    end
    @(posedge clk);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
  endtask

  task automatic read_txn(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr);
    exp_q.push_back(ref_access(1'b1, id, addr, '0, '0));
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_i.id    <= id;
    ar_i.addr  <= addr;
    @(negedge clk);
    while (!ar_ready_o) @(negedge clk);
    @(posedge clk);
    ar_valid_i <= 1'b0;
  endtask

  task automatic write_txn(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    exp_q.push_back(ref_access(1'b0, id, addr, data, strb));
    @(posedge clk);
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    aw_i.id    <= id;
    aw_i.addr  <= addr;
    w_i.data   <= data;
    w_i.strb   <= strb;
    wait_write_accept();
  endtask

  // read and write raised together, the read must go first
  task automatic read_write_txn(input logic [ID_W-1:0] rid, input logic [ADDR_W-1:0] raddr,
                                input logic [ID_W-1:0] wid, input logic [ADDR_W-1:0] waddr,
                                input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
    exp_q.push_back(ref_access(1'b1, rid, raddr, '0, '0));
    exp_q.push_back(ref_access(1'b0, wid, waddr, data, strb));
    @(posedge clk);
    ar_valid_i <= 1'b1;
    ar_i.id    <= rid;
    ar_i.addr  <= raddr;
    aw_valid_i <= 1'b1;
    w_valid_i  <= 1'b1;
    aw_i.id    <= wid;
    aw_i.addr  <= waddr;
    w_i.data   <= data;
    w_i.strb   <= strb;
    do begin
      @(negedge clk);
      assert (!aw_ready_o && !w_ready_o) else begin
        errors++;
        $display("FAILED @ %0t: write accepted while a read was pending", $time);
      end
    end while (!ar_ready_o);
    @(posedge clk);
    ar_valid_i <= 1'b0;
    wait_write_accept();
  endtask

  // random ready delays on the response channels
  always @(posedge clk) begin
    if (rst_i) begin
      r_ready_i <= 1'b0;
      b_ready_i <= 1'b0;
    end else begin
      r_ready_i <= ($random(ready_seed) & 3) != 0;
      b_ready_i <= ($random(ready_seed) & 3) != 0;
    end
  end

  // compare at the falling edge where outputs are settled
  always @(negedge clk) begin
    if (!rst_i) begin
      if (r_valid_o) begin
        if (r_held) begin
          assert (r_o == r_last) else begin
            errors++;
            $display("FAILED @ %0t: held R payload changed to %h", $time, r_o);
          end
        end
        if (r_ready_i) begin
          r_held = 1'b0;
          assert (exp_q.size() > 0) else begin
            errors++;
            $display("R response with id %0h arrived with nothing outstanding", r_o.id);
          end
          if (exp_q.size() > 0) begin
            exp_cur = exp_q.pop_front();
            checked++;
            assert (exp_cur.is_read && r_o.id == exp_cur.id && r_o.data == exp_cur.data &&
                    r_o.resp == exp_cur.resp) else begin
              errors++;
              $display({"FAILED @ %0t: R id %0h data %h resp %0d, ",
                        "expected %s id %0h data %h resp %0d"},
                       $time, r_o.id, r_o.data, r_o.resp, exp_cur.is_read ? "R" : "B",
                       exp_cur.id, exp_cur.data, exp_cur.resp);
            end
          end
        end else begin
          r_held = 1'b1;
          r_last = r_o;
        end
      end
      if (b_valid_o) begin
        if (b_held) begin
          assert (b_o == b_last) else begin
            errors++;
            $display("FAILED @ %0t: held B payload changed to %h", $time, b_o);
          end
        end
        if (b_ready_i) begin
          b_held = 1'b0;
          assert (exp_q.size() > 0) else begin
            errors++;
            $display("B response with id %0h arrived with nothing outstanding", b_o.id);
          end
          if (exp_q.size() > 0) begin
            exp_cur = exp_q.pop_front();
            checked++;
            assert (!exp_cur.is_read && b_o.id == exp_cur.id && b_o.resp == exp_cur.resp)
            else begin
              errors++;
              $display("FAILED @ %0t: B id %0h resp %0d, expected %s id %0h resp %0d",
                       $time, b_o.id, b_o.resp, exp_cur.is_read ? "R" : "B",
                       exp_cur.id, exp_cur.resp);
            end
          end
        end else begin
          b_held = 1'b1;
          b_last = b_o;
        end
      end
      if (uart_valid_o) begin
        uart_pulses++;
        assert (uart_q.size() > 0 && uart_data_o == uart_q[0]) else begin
          errors++;
          $display("FAILED @ %0t: console byte %h not expected", $time, uart_data_o);
        end
        if (uart_q.size() > 0) begin
          void'(uart_q.pop_front());
        end
      end
    end
  end

  initial begin
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the DUT stopped responding after %0d cycles", cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin : stimulus
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    int unsigned       kind;
    logic              is_rd;
    rst_i      = 1'b1;
    ar_valid_i = 1'b0;
    ar_i       = '0;
    aw_valid_i = 1'b0;
    aw_i       = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    errors     = 0;
    r_held     = 1'b0;
    b_held     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;

    // known contents everywhere before any read
    for (int i = 0; i < TB_WORDS; i++) begin
      data[31:0]  = $random(seed);
      data[63:32] = $random(seed);
      write_txn(4'(i), `MEM_BASE + i * 8, data, 8'hff);
    end

    // strobe merge
    write_txn(4'h1, `MEM_BASE + 3 * 8, 64'h0123_4567_89ab_cdef, 8'hff);
    write_txn(4'h2, `MEM_BASE + 3 * 8, 64'hfedc_ba98_7654_3210, 8'ha5);
    read_txn(4'h3, `MEM_BASE + 3 * 8);

    // console byte, then a read of the port
    write_txn(4'h4, `SERIAL_ADDR, 64'h1111_2222_3333_44c3, 8'h01);
    read_txn(4'h5, `SERIAL_ADDR);

    // decode errors, one just past the end would alias word 0 on a bad index
    write_txn(4'h6, `MEM_BASE - 8, 64'hdead_beef_dead_beef, 8'hff);
    write_txn(4'h7, `MEM_BASE + TB_WORDS * 8, 64'hcafe_f00d_cafe_f00d, 8'hff);
    read_txn(4'h8, 32'h0000_1000);
    read_txn(4'h9, `MEM_BASE + TB_WORDS * 8);
    read_txn(4'ha, `MEM_BASE);
    read_txn(4'hb, `MEM_BASE + (TB_WORDS - 1) * 8);

    // same word, the read must see the old value
    read_write_txn(4'hc, `MEM_BASE + 3 * 8, 4'hd, `MEM_BASE + 3 * 8,
                   64'h5555_6666_7777_8888, 8'h0f);
    read_txn(4'he, `MEM_BASE + 3 * 8);

    for (int n = 0; n < RAND_TXN; n++) begin
      kind        = $random(seed) & 15;
      is_rd       = $random(seed) & 1;
      id          = $random(seed);
      data[31:0]  = $random(seed);
      data[63:32] = $random(seed);
      strb        = $random(seed);
      if (kind < 11) begin
        addr = `MEM_BASE + ((($random(seed) & 32'hff) % TB_WORDS) << 3);
      end else if (kind < 13) begin
        addr = `SERIAL_ADDR;
      end else if (kind < 15) begin
        addr = 32'h1000_0000 + (($random(seed) & 32'hffff) << 3);
      end else begin
        addr = `MEM_BASE + TB_WORDS * 8 + (($random(seed) & 32'hff) << 3);
      end
      if (is_rd) begin
        read_txn(id, addr);
      end else begin
        write_txn(id, addr, data, strb);
      end
    end

    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    assert (uart_q.size() == 0 && uart_pulses == serial_writes) else begin
      errors++;
      $display("console saw %0d bytes for %0d serial writes", uart_pulses, serial_writes);
    end
    errors += axi_mem_top_i.assertions_i.fail_count;
    $display("%0d responses checked, %0d console bytes, %0d errors (%0d from assertions)",
             checked, uart_pulses, errors, axi_mem_top_i.assertions_i.fail_count);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+include
hw/axi_bus_pkg.sv
hw/mem_dev_pkg.sv
hw/axi_req_capture.sv
hw/mem_core.sv
hw/axi_resp_gen.sv
hw/axi_mem_top.sv
verif/axi_mem_assertions.sv
verif/tb_axi_mem.sv

//--- Bender.yml
package:
  name: axi_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/axi_bus_pkg.sv
      - hw/mem_dev_pkg.sv
      - hw/axi_req_capture.sv
      - hw/mem_core.sv
      - hw/axi_resp_gen.sv
      - hw/axi_mem_top.sv

  - target: test
    include_dirs:
      - include
    files:
      - verif/axi_mem_assertions.sv
      - verif/tb_axi_mem.sv
